//--- axi_ddr_pkg.sv
package axi_ddr_pkg;

    typedef logic [3:0]   axi_id_t;
    typedef logic [31:0]  axi_addr_t;
    typedef logic [7:0]   axi_len_t;     // beats = len + 1
    typedef logic [31:0]  axi_data_t;
    typedef logic [3:0]   axi_strb_t;
    typedef logic [1:0]   axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_DECERR = 2'd3;

    typedef logic [255:0] line_data_t;   // one native line
    typedef logic [31:0]  line_strb_t;   // byte enables of a line
    typedef logic [22:0]  line_addr_t;   // byte address bits 27:5

    localparam int BEATS_PER_LINE = 8;

    // controller sequencing
    typedef enum logic [2:0] {
        ST_INIT,
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_REFRESH
    } ctrl_state_t;

endpackage

//--- axi_rd_bridge.sv
`timescale 1ns/1ns

module axi_rd_bridge #(
    parameter int MEM_LINES = 64
) (
    input  logic                   ddr_ref_clk,
    input  logic                   arst_n,
    input  logic                   init_done,
    input  axi_ddr_pkg::axi_id_t   arid,
    input  axi_ddr_pkg::axi_addr_t araddr,
    input  axi_ddr_pkg::axi_len_t  arlen,
    input  logic [1:0]             arburst,     // incr only, not decoded
    input  logic                   arvalid,
    output logic                   arready,
    output axi_ddr_pkg::axi_id_t   rid,
    output axi_ddr_pkg::axi_data_t rdata,
    output axi_ddr_pkg::axi_resp_t rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    mem_port_if.client             port
);
    import axi_ddr_pkg::*;

    typedef enum logic [1:0] {R_IDLE, R_FETCH, R_WAIT, R_BEAT} rd_state_t;

    rd_state_t  state;
    axi_id_t    id_q;
    axi_addr_t  addr_q;      // address of the current beat
    axi_len_t   len_q;
    axi_len_t   beat_cnt;
    axi_resp_t  resp_q;
    line_data_t line_q;
    logic [2:0] lane;
    logic       in_range;

    assign lane     = addr_q[4:2];
    assign in_range = addr_q[27:5] < line_addr_t'(MEM_LINES);

    assign arready = init_done && state == R_IDLE;
    assign rvalid  = state == R_BEAT;
    assign rid     = id_q;
    assign rdata   = line_q[lane*32 +: 32];
    assign rresp   = resp_q;
    assign rlast   = beat_cnt == len_q;

    assign port.req       = state == R_FETCH && in_range;
    assign port.we        = 1'b0;
    assign port.line_addr = addr_q[27:5];
    assign port.wdata     = '0;
    assign port.wstrb     = '0;

    always_ff @(posedge ddr_ref_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= R_IDLE;
            beat_cnt <= '0;
            resp_q   <= RESP_OKAY;
        end else begin
            case (state)
                R_IDLE: if (arvalid && arready) begin
                    beat_cnt <= '0;
                    state    <= R_FETCH;
                end
                R_FETCH: if (!in_range) begin
                    resp_q <= RESP_DECERR;      // zero beats, no fetch
                    state  <= R_BEAT;
                end else if (port.ready) begin
                    resp_q <= RESP_OKAY;
                    state  <= R_WAIT;
                end
                R_WAIT: if (port.rvalid) begin
                    state <= R_BEAT;
                end
                R_BEAT: if (rready) begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (rlast) begin
                        state <= R_IDLE;
                    end else if (lane == 3'(BEATS_PER_LINE - 1)) begin
                        state <= R_FETCH;       // next line once this one is drained
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge ddr_ref_clk) begin
        if (arvalid && arready) begin
            id_q   <= arid;
            addr_q <= araddr;
            len_q  <= arlen;
        end else if (rvalid && rready) begin
            addr_q <= addr_q + 32'd4;
        end
        if (state == R_FETCH && !in_range) begin
            line_q <= '0;
        end else if (state == R_WAIT && port.rvalid) begin
            line_q <= port.rdata;
        end
    end

    a_r_stable: assert property (@(posedge ddr_ref_clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
        else $error("read beat changed while stalled");

    // controller forward plus registered store read
    a_line_latency: assert property (@(posedge ddr_ref_clk) disable iff (!arst_n)
        port.req && port.ready |-> ##2 port.rvalid)
        else $error("line read latency not 2 cycles");

endmodule

//--- axi_wr_bridge.sv
`timescale 1ns/1ns

module axi_wr_bridge #(
    parameter int MEM_LINES = 64
) (
    input  logic                   ddr_ref_clk,
    input  logic                   arst_n,
    input  logic                   init_done,
    input  axi_ddr_pkg::axi_id_t   awid,
    input  axi_ddr_pkg::axi_addr_t awaddr,
    input  axi_ddr_pkg::axi_len_t  awlen,
    input  logic [1:0]             awburst,     // incr only, not decoded
    input  logic                   awvalid,
    output logic                   awready,
    input  axi_ddr_pkg::axi_data_t wdata,
    input  axi_ddr_pkg::axi_strb_t wstrb,
    input  logic                   wlast,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_ddr_pkg::axi_id_t   bid,
    output axi_ddr_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,
    mem_port_if.client             port
);
    import axi_ddr_pkg::*;

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_ISSUE, W_RESP} wr_state_t;

    wr_state_t  state;
    axi_id_t    id_q;
    axi_addr_t  addr_q;      // address of the next beat
    axi_len_t   len_q;
    axi_len_t   beat_cnt;
    axi_resp_t  resp_q;
    line_addr_t line_q;      // line of the buffered beats
    line_data_t buf_data;
    line_strb_t buf_strb;
    logic       last_q;
    logic [2:0] lane;
    logic       in_range;

    assign lane     = addr_q[4:2];
    assign in_range = line_q < line_addr_t'(MEM_LINES);

    assign awready = init_done && state == W_IDLE;
    assign wready  = state == W_DATA;
    assign bvalid  = state == W_RESP;
    assign bid     = id_q;
    assign bresp   = resp_q;

    assign port.req       = state == W_ISSUE && in_range;    // out of range lines are dropped
    assign port.we        = 1'b1;
    assign port.line_addr = line_q;
    assign port.wdata     = buf_data;
    assign port.wstrb     = buf_strb;

    always_ff @(posedge ddr_ref_clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= W_IDLE;
            beat_cnt <= '0;
            buf_strb <= '0;
            resp_q   <= RESP_OKAY;
            last_q   <= 1'b0;
        end else begin
            case (state)
                W_IDLE: if (awvalid && awready) begin
                    beat_cnt <= '0;
                    buf_strb <= '0;
                    resp_q   <= RESP_OKAY;
                    state    <= W_DATA;
                end
                W_DATA: if (wvalid) begin
                    buf_strb[lane*4 +: 4] <= wstrb;
                    beat_cnt <= beat_cnt + 1'b1;
                    last_q   <= wlast;
                    if (wlast || lane == 3'(BEATS_PER_LINE - 1)) begin
                        state <= W_ISSUE;
                    end
                end
                W_ISSUE: if (port.ready || !in_range) begin
                    buf_strb <= '0;
                    if (!in_range) begin
                        resp_q <= RESP_DECERR;
                    end
                    state <= last_q ? W_RESP : W_DATA;
                end
                W_RESP: if (bready) begin
                    state <= W_IDLE;
                end
                default: state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge ddr_ref_clk) begin
        if (awvalid && awready) begin
            id_q   <= awid;
            addr_q <= awaddr;
            len_q  <= awlen;
        end else if (wvalid && wready) begin
            buf_data[lane*32 +: 32] <= wdata;
            line_q <= addr_q[27:5];
            addr_q <= addr_q + 32'd4;
        end
    end

    a_wlast_on_len: assert property (@(posedge ddr_ref_clk) disable iff (!arst_n)
        wvalid && wready |-> wlast == (beat_cnt == len_q))
        else $error("wlast not on beat len");

    a_wdata_stable: assert property (@(posedge ddr_ref_clk) disable iff (!arst_n)
        wvalid && !wready |=> $stable(wdata))
        else $error("wdata changed while stalled");

endmodule

//--- mem_ctrl.sv
`timescale 1ns/1ns

module mem_ctrl #(
    parameter int INIT_CYCLES      = 40,
    parameter int REFRESH_INTERVAL = 200,
    parameter int REFRESH_CYCLES   = 6
) (
    input  logic       ddr_ref_clk,
    input  logic       arst_n,
    output logic       init_done,
    mem_port_if.ctrl   wr_port,
    mem_port_if.ctrl   rd_port,
    mem_port_if.client st_port
);
    import axi_ddr_pkg::*;

    localparam int CW = $clog2(INIT_CYCLES + REFRESH_CYCLES + 1);
    localparam int RW = $clog2(REFRESH_INTERVAL + 1);

    ctrl_state_t   state;
    logic [CW-1:0] cnt;          // init and refresh length
    logic [RW-1:0] ref_timer;
    logic          ref_pend;
    logic          last_wr;      // last grant went to the write port
    logic          grant_wr;
    logic          grant_rd;
    logic          idle_ok;
    line_addr_t    line_q;
    line_data_t    wdata_q;
    line_strb_t    wstrb_q;

    assign idle_ok  = state == ST_IDLE && !ref_pend;
    assign grant_wr = wr_port.req && (!rd_port.req || !last_wr);
    assign grant_rd = rd_port.req && (!wr_port.req || last_wr);

    assign wr_port.ready  = idle_ok && grant_wr;
    assign rd_port.ready  = idle_ok && grant_rd;
    assign wr_port.rvalid = 1'b0;
    assign wr_port.rdata  = '0;
    assign rd_port.rvalid = st_port.rvalid;     // only reads return data
    assign rd_port.rdata  = st_port.rdata;

    assign st_port.req       = state == ST_WRITE || state == ST_READ;
    assign st_port.we        = state == ST_WRITE;
    assign st_port.line_addr = line_q;
    assign st_port.wdata     = wdata_q;
    assign st_port.wstrb     = wstrb_q;

    always_ff @(posedge ddr_ref_clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_INIT;
            cnt       <= '0;
            ref_timer <= '0;
            ref_pend  <= 1'b0;
            init_done <= 1'b0;
            last_wr   <= 1'b0;
        end else begin
            if (init_done) begin
                if (ref_timer == RW'(REFRESH_INTERVAL - 1)) begin
                    ref_timer <= '0;
                    ref_pend  <= 1'b1;
                end else begin
                    ref_timer <= ref_timer + 1'b1;
                end
            end
            case (state)
                ST_INIT: if (cnt == CW'(INIT_CYCLES - 1)) begin
                    cnt       <= '0;
                    init_done <= 1'b1;
                    state     <= ST_IDLE;
                end else begin
                    cnt <= cnt + 1'b1;
                end
                ST_IDLE: if (ref_pend) begin
                    ref_pend <= 1'b0;
                    state    <= ST_REFRESH;     // pending requests wait
                end else if (grant_wr) begin
                    last_wr <= 1'b1;
                    state   <= ST_WRITE;
                end else if (grant_rd) begin
                    last_wr <= 1'b0;
                    state   <= ST_READ;
                end
                ST_WRITE, ST_READ: state <= ST_IDLE;
                ST_REFRESH: if (cnt == CW'(REFRESH_CYCLES - 1)) begin
                    cnt   <= '0;
                    state <= ST_IDLE;
                end else begin
                    cnt <= cnt + 1'b1;
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge ddr_ref_clk) begin
        if (wr_port.ready) begin
            line_q  <= wr_port.line_addr;
            wdata_q <= wr_port.wdata;
            wstrb_q <= wr_port.wstrb;
        end else if (rd_port.ready) begin
            line_q <= rd_port.line_addr;
        end
    end

    a_one_grant: assert property (@(posedge ddr_ref_clk) disable iff (!arst_n)
        !(wr_port.ready && rd_port.ready))
        else $error("both ports granted");

endmodule

//--- mem_port_if.sv
`timescale 1ns/1ns

interface mem_port_if;
    import axi_ddr_pkg::*;

    logic       req;
    logic       we;          // 1 write, 0 read
    line_addr_t line_addr;
    line_data_t wdata;
    line_strb_t wstrb;
    logic       ready;       // accepts req at the clock edge
    logic       rvalid;      // read line 2 cycles after acceptance
    line_data_t rdata;

    modport client (
        output req, we, line_addr, wdata, wstrb,
        input  ready, rvalid, rdata
    );

    modport ctrl (
        input  req, we, line_addr, wdata, wstrb,
        output ready, rvalid, rdata
    );

    // the store takes every request it sees
    modport target (
        input  req, we, line_addr, wdata, wstrb,
        output rvalid, rdata
    );

endinterface

//--- mem_store.sv
`timescale 1ns/1ns

module mem_store #(
    parameter int MEM_LINES = 64
) (
    input  logic       ddr_ref_clk,
    input  logic       arst_n,
    mem_port_if.target port
);
    import axi_ddr_pkg::*;

    localparam int AW = $clog2(MEM_LINES);

    line_data_t    mem [MEM_LINES] = '{default: '0};
    logic [AW-1:0] idx;

    assign idx = port.line_addr[AW-1:0];        // bridges keep lines in range

    always_ff @(posedge ddr_ref_clk) begin
        if (port.req && port.we) begin
            for (int i = 0; i < 32; i++) begin
                if (port.wstrb[i]) begin
                    mem[idx][i*8 +: 8] <= port.wdata[i*8 +: 8];
                end
            end
        end
        if (port.req && !port.we) begin
            port.rdata <= mem[idx];
        end
    end

    always_ff @(posedge ddr_ref_clk or negedge arst_n) begin
        if (!arst_n) begin
            port.rvalid <= 1'b0;
        end else begin
            port.rvalid <= port.req && !port.we;    // one cycle after the read
        end
    end

endmodule

//--- slave_ddr3.f
axi_ddr_pkg.sv
mem_port_if.sv
axi_wr_bridge.sv
axi_rd_bridge.sv
mem_ctrl.sv
mem_store.sv
slave_ddr3.sv
tb_slave_ddr3.sv

//--- slave_ddr3.sv
`timescale 1ns/1ns

module slave_ddr3 #(
    parameter int MEM_LINES        = 64,
    parameter int INIT_CYCLES      = 40,
    parameter int REFRESH_INTERVAL = 200,
    parameter int REFRESH_CYCLES   = 6
) (
    input  logic                   ddr_ref_clk,
    input  logic                   arst_n,
    output logic                   ddr_init_done,

    input  axi_ddr_pkg::axi_id_t   awid,
    input  axi_ddr_pkg::axi_addr_t awaddr,
    input  axi_ddr_pkg::axi_len_t  awlen,
    input  logic [1:0]             awburst,
    input  logic                   awvalid,
    output logic                   awready,

    input  axi_ddr_pkg::axi_data_t wdata,
    input  axi_ddr_pkg::axi_strb_t wstrb,
    input  logic                   wlast,
    input  logic                   wvalid,
    output logic                   wready,

    output axi_ddr_pkg::axi_id_t   bid,
    output axi_ddr_pkg::axi_resp_t bresp,
    output logic                   bvalid,
    input  logic                   bready,

    input  axi_ddr_pkg::axi_id_t   arid,
    input  axi_ddr_pkg::axi_addr_t araddr,
    input  axi_ddr_pkg::axi_len_t  arlen,
    input  logic [1:0]             arburst,
    input  logic                   arvalid,
    output logic                   arready,

    output axi_ddr_pkg::axi_id_t   rid,
    output axi_ddr_pkg::axi_data_t rdata,
    output axi_ddr_pkg::axi_resp_t rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready
);

    mem_port_if wr_port ();
    mem_port_if rd_port ();
    mem_port_if st_port ();

    axi_wr_bridge #(.MEM_LINES(MEM_LINES)) i_wr_bridge (
        .ddr_ref_clk (ddr_ref_clk),
        .arst_n      (arst_n),
        .init_done   (ddr_init_done),
        .awid        (awid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awburst     (awburst),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bid         (bid),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .port        (wr_port)
    );

    axi_rd_bridge #(.MEM_LINES(MEM_LINES)) i_rd_bridge (
        .ddr_ref_clk (ddr_ref_clk),
        .arst_n      (arst_n),
        .init_done   (ddr_init_done),
        .arid        (arid),
        .araddr      (araddr),
        .arlen       (arlen),
        .arburst     (arburst),
        .arvalid     (arvalid),
        .arready     (arready),
        .rid         (rid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .port        (rd_port)
    );

    mem_ctrl #(
        .INIT_CYCLES      (INIT_CYCLES),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .REFRESH_CYCLES   (REFRESH_CYCLES)
    ) i_mem_ctrl (
        .ddr_ref_clk (ddr_ref_clk),
        .arst_n      (arst_n),
        .init_done   (ddr_init_done),
        .wr_port     (wr_port),
        .rd_port     (rd_port),
        .st_port     (st_port)
    );

    mem_store #(.MEM_LINES(MEM_LINES)) i_mem_store (
        .ddr_ref_clk (ddr_ref_clk),
        .arst_n      (arst_n),
        .port        (st_port)
    );

endmodule

//--- slave_ddr3_testdata.txt
# op name id addr(hex) len(dec) seed(hex) strb(hex), one transaction per line
# write beat k carries seed+k; reads ignore seed and strb
W aligned_wr  3 00000000 7   a5000000 f
R aligned_rd  3 00000000 7   00000000 0
W single_wr   1 00000040 0   12345678 f
R single_rd   1 00000040 0   00000000 0
W partial_wr  5 00000114 19  c0de0000 5
W overlay_wr  6 00000108 3   77770000 c
R partial_rd  7 00000100 31  00000000 0
W oor_wr      9 00000800 7   deadbeef f
R keep_rd     a 00000000 7   00000000 0
R oor_rd      9 00000820 3   00000000 0
W edge_wr     b 000007f0 7   5a5a0000 f
R edge_rd     b 000007f0 7   00000000 0
W long_wr     c 00000400 255 10000000 f
R long_rd     d 00000400 255 00000000 0
R mid_rd      e 000004c4 2   00000000 0

//--- tb_slave_ddr3.sv
`timescale 1ns/1ns

module tb_slave_ddr3;
    import axi_ddr_pkg::*;

    localparam int MEM_LINES        = 64;
    localparam int INIT_CYCLES      = 40;
    localparam int REFRESH_INTERVAL = 200;
    localparam int REFRESH_CYCLES   = 6;
    localparam int MAX_TESTS        = 64;
    localparam int RESET_CYCLES     = 3;

    logic       ddr_ref_clk = 1'b0;
    logic       arst_n;
    logic       ddr_init_done;
    axi_id_t    awid, bid, arid, rid;
    axi_addr_t  awaddr, araddr;
    axi_len_t   awlen, arlen;
    logic [1:0] awburst, arburst;
    logic       awvalid, awready, arvalid, arready;
    axi_data_t  wdata, rdata;
    axi_strb_t  wstrb;
    logic       wlast, wvalid, wready;
    axi_resp_t  bresp, rresp;
    logic       bvalid, bready, rlast, rvalid, rready;

    // transactions loaded from the data file
    logic [7:0]      t_op   [MAX_TESTS];
    logic [8*24-1:0] t_name [MAX_TESTS];
    axi_id_t         t_id   [MAX_TESTS];
    axi_addr_t       t_addr [MAX_TESTS];
    int              t_len  [MAX_TESTS];
    axi_data_t       t_seed [MAX_TESTS];
    axi_strb_t       t_strb [MAX_TESTS];
    int              n_tests;
    int              total_beats;
    logic            loaded = 1'b0;
    logic            init_seen = 1'b0;
    logic [31:0]     lfsr;
    logic [7:0]      ref_mem [MEM_LINES*32];     // byte image of the line store

    slave_ddr3 #(
        .MEM_LINES        (MEM_LINES),
        .INIT_CYCLES      (INIT_CYCLES),
        .REFRESH_INTERVAL (REFRESH_INTERVAL),
        .REFRESH_CYCLES   (REFRESH_CYCLES)
    ) i_slave_ddr3 (
        .ddr_ref_clk (ddr_ref_clk), .arst_n (arst_n), .ddr_init_done (ddr_init_done),
        .awid (awid), .awaddr (awaddr), .awlen (awlen), .awburst (awburst),
        .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wvalid (wvalid), .wready (wready),
        .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .arid (arid), .araddr (araddr), .arlen (arlen), .arburst (arburst),
        .arvalid (arvalid), .arready (arready),
        .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast), .rvalid (rvalid),
        .rready (rready)
    );

    always #5 ddr_ref_clk = ~ddr_ref_clk;     // 10 ns period

    task automatic abort_sim();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [8*24-1:0] test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %0s expected %h actual %h", test_name, expected, actual);
            abort_sim();
        end
    endtask

    // taps 32 22 2 1
    function automatic logic rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic line_ok(input axi_addr_t a);
        return a[27:5] < MEM_LINES;
    endfunction

    function automatic axi_data_t model_word(input axi_addr_t a);
        int i;
        i = int'(a[27:0]);
        return {ref_mem[i+3], ref_mem[i+2], ref_mem[i+1], ref_mem[i]};
    endfunction

    task automatic load_tests();
        int              fd;
        int              code;
        logic [63:0]     tok;
        logic [8*80-1:0] rest;
        logic [8*24-1:0] name;
        axi_id_t         id;
        axi_addr_t       addr;
        int              len;
        axi_data_t       seed;
        axi_strb_t       strb;
        fd = $fopen("slave_ddr3_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file slave_ddr3_testdata.txt");
            abort_sim();
        end
        n_tests     = 0;
        total_beats = 0;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);     // skip column notes
            end else begin
                code = $fscanf(fd, "%s %h %h %d %h %h", name, id, addr, len, seed, strb);
                if (code != 6 || !(tok == "W" || tok == "R") || n_tests == MAX_TESTS) begin
                    $display("malformed or extra line in the test data file, entry %0d", n_tests);
                    abort_sim();
                end
                t_op[n_tests]   = tok[7:0];
                t_name[n_tests] = name;
                t_id[n_tests]   = id;
                t_addr[n_tests] = addr;
                t_len[n_tests]  = len;
                t_seed[n_tests] = seed;
                t_strb[n_tests] = strb;
                total_beats     = total_beats + len + 1;
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_for_init();
        int cycles;
        cycles = 0;
        while (!ddr_init_done) begin
            check_value("init_quiet", 0, {awready, wready, arready, bvalid, rvalid});
            @(negedge ddr_ref_clk);
            cycles++;
        end
        check_value("init_length", INIT_CYCLES, cycles);
        init_seen = 1'b1;
    endtask

    task automatic run_write(input int t);
        int        k;
        logic      xfer;
        logic      stalled;
        axi_resp_t exp_resp;
        axi_addr_t a;
        awid    = t_id[t];
        awaddr  = t_addr[t];
        awlen   = axi_len_t'(t_len[t]);
        awburst = 2'b01;
        while (!(awvalid && awready)) begin
            @(negedge ddr_ref_clk);
            if (!awvalid) begin
                awvalid = rand_bit();
            end
        end
        k        = 0;
        xfer     = 1'b0;
        exp_resp = RESP_OKAY;
        while (k <= t_len[t]) begin
            @(negedge ddr_ref_clk);
            awvalid = 1'b0;
            if (xfer || !wvalid) begin      // pick the next beat or gap
                xfer   = 1'b0;
                wvalid = rand_bit();
                wdata  = t_seed[t] + k;
                wstrb  = t_strb[t];
                wlast  = k == t_len[t];
            end
            if (wvalid && wready) begin
                a = t_addr[t] + 4 * k;
                if (line_ok(a)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) begin
                            ref_mem[int'(a[27:0]) + b] = wdata[b*8 +: 8];
                        end
                    end
                end else begin
                    exp_resp = RESP_DECERR;     // beat dropped
                end
                xfer = 1'b1;
                k++;
            end
        end
        stalled = 1'b0;
        xfer    = 1'b0;
        while (!xfer) begin
            @(negedge ddr_ref_clk);
            wvalid = 1'b0;
            wlast  = 1'b0;
            if (stalled) begin
                check_value(t_name[t], 1, bvalid);      // bvalid must wait for bready
            end
            bready  = rand_bit();
            stalled = bvalid && !bready;
            if (bvalid && bready) begin
                check_value(t_name[t], t_id[t], bid);
                check_value(t_name[t], exp_resp, bresp);
                xfer = 1'b1;
            end
        end
    endtask

    task automatic run_read(input int t);
        int        k;
        logic      stalled;
        axi_data_t held_data;
        logic      held_last;
        axi_addr_t a;
        arid    = t_id[t];
        araddr  = t_addr[t];
        arlen   = axi_len_t'(t_len[t]);
        arburst = 2'b01;
        while (!(arvalid && arready)) begin
            @(negedge ddr_ref_clk);
            if (!arvalid) begin
                arvalid = rand_bit();
            end
        end
        k       = 0;
        stalled = 1'b0;
        while (k <= t_len[t]) begin
            @(negedge ddr_ref_clk);
            arvalid = 1'b0;
            if (stalled) begin
                check_value(t_name[t], 1, rvalid);
                check_value(t_name[t], held_data, rdata);
                check_value(t_name[t], held_last, rlast);
            end
            rready    = rand_bit();
            stalled   = rvalid && !rready;
            held_data = rdata;
            held_last = rlast;
            if (rvalid && rready) begin
                a = t_addr[t] + 4 * k;
                check_value(t_name[t], t_id[t], rid);
                check_value(t_name[t], line_ok(a) ? model_word(a) : 32'd0, rdata);
                check_value(t_name[t], line_ok(a) ? RESP_OKAY : RESP_DECERR, rresp);
                check_value(t_name[t], k == t_len[t], rlast);
                k++;
            end
        end
    endtask

    always @(negedge ddr_ref_clk) begin
        if (init_seen) begin
            check_value("init_hold", 1, ddr_init_done);
        end
    end

    initial begin
        wait (loaded);
        repeat (total_beats * 50 + INIT_CYCLES + RESET_CYCLES) @(posedge ddr_ref_clk);
        $display("timeout: the transactions did not finish within %0d cycles",
                 total_beats * 50 + INIT_CYCLES + RESET_CYCLES);
        abort_sim();
    end

    initial begin
        lfsr    = 32'h778dce1f;
        arst_n  = 1'b0;
        awid    = '0;
        awaddr  = '0;
        awlen   = '0;
        awburst = 2'b01;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wlast   = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arburst = 2'b01;
        arvalid = 1'b0;
        rready  = 1'b0;
        for (int i = 0; i < MEM_LINES * 32; i++) begin
            ref_mem[i] = 8'h00;
        end
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge ddr_ref_clk);
        arst_n = 1'b1;
        wait_for_init();
        for (int t = 0; t < n_tests; t++) begin
            if (t_op[t] == "W") begin
                run_write(t);
            end else begin
                run_read(t);
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule
